// ==== src/cpuPkg.sv ====
package cpuPkg;

    // Primary opcodes, MIPS encodings.
    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpAddiu = 6'h09,
        OpLui   = 6'h0F,
        OpLw    = 6'h23,
        OpSw    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2A
    } funct_t;

    typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluLui} aluOp_t;

    typedef enum logic [1:0] {LsAlu, LsLoad, LsStore} lsKind_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;   // Byte address, always word aligned.
        logic [31:0] data;
    } memReq_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } memRsp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetchBundle_t;

    typedef struct packed {
        lsKind_t     kind;
        logic [4:0]  dest;
        logic        wrEn;
        logic [31:0] result;    // ALU result, or the address for loads and stores.
        logic [31:0] storeData;
    } lsBundle_t;

endpackage

// ==== src/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic        Clock,
    input  logic        nReset,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [32];

    // Register zero reads as zero and a same cycle write is passed straight through.
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;
        else if (wrEn && wrAddr == addr)
            return wrData;
        else
            return regs[addr];
    endfunction

    assign rsData = readPort(rsAddr);
    assign rtData = readPort(rtAddr);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// ==== src/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit #(
    parameter logic [31:0] ResetPc = 32'h0
) (
    input  logic                 Clock,
    input  logic                 nReset,
    output cpuPkg::memReq_t      fetchReq,
    input  logic                 fetchReqReady,
    input  cpuPkg::memRsp_t      fetchRsp,
    output cpuPkg::fetchBundle_t fetch,
    output logic                 fetchValid,
    input  logic                 fetchReady,
    input  logic                 redirect,
    input  logic [31:0]          redirectPc
);
    import cpuPkg::*;

    typedef enum logic [1:0] {FetchIdle, FetchWait, FetchHold} fetchState_t;

    fetchState_t state;
    logic [31:0] pc;
    logic [31:0] reqPc;
    logic [31:0] holdWord;
    logic        discard;
    logic        accepted;

    always_comb begin
        fetchReq       = '0;
        fetchReq.valid = nReset && (state == FetchIdle); // No request while held in reset.
        fetchReq.addr  = pc;
    end

    assign accepted   = fetchReq.valid && fetchReqReady;
    assign fetchValid = (state == FetchHold);
    assign fetch      = '{pc: reqPc, instr: holdWord};

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            state   <= FetchIdle;
            pc      <= ResetPc;
            discard <= 1'b0;
        end else begin
            case (state)
                FetchIdle: begin
                    // A request already on the bus must stay stable, so a redirect
                    // only marks it stale.
                    if (accepted) begin
                        state <= FetchWait;
                        pc    <= pc + 32'd4;
                    end
                    if (redirect)
                        discard <= 1'b1;
                end
                FetchWait: begin
                    if (fetchRsp.valid) begin
                        discard <= 1'b0;
                        if (discard || redirect) begin
                            state <= FetchIdle;
                            pc    <= redirect ? redirectPc : reqPc; // Restart on the new path.
                        end else begin
                            state <= FetchHold;
                        end
                    end else if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                default: begin
                    if (redirect) begin
                        state <= FetchIdle;
                        pc    <= redirectPc;
                    end else if (fetchReady) begin
                        state <= FetchIdle;
                    end
                end
            endcase
        end
    end

    // While a stale request is in flight reqPc holds the redirect target.
    always_ff @(posedge Clock) begin
        if (redirect)
            reqPc <= redirectPc;
        else if (accepted && !discard)
            reqPc <= pc;
        if (state == FetchWait && fetchRsp.valid)
            holdWord <= fetchRsp.data;
    end

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  logic                 Clock,
    input  logic                 nReset,
    input  cpuPkg::fetchBundle_t fetch,
    input  logic                 fetchValid,
    output logic                 fetchReady,
    output logic [4:0]           rsAddr,
    output logic [4:0]           rtAddr,
    input  logic [31:0]          rsData,
    input  logic [31:0]          rtData,
    input  logic [4:0]           busyDest,
    input  logic                 busyValid,
    output cpuPkg::lsBundle_t    ls,
    output logic                 lsValid,
    input  logic                 lsReady,
    output logic                 redirect,
    output logic [31:0]          redirectPc
);
    import cpuPkg::*;

    fetchBundle_t cur;
    logic         curValid;
    opcode_t      op;
    funct_t       fn;
    aluOp_t       aluOp;
    lsKind_t      kind;
    logic [4:0]   dest;
    logic         writes;
    logic         useRs;
    logic         useRt;
    logic [31:0]  immExt;
    logic [31:0]  operandB;
    logic [31:0]  aluResult;
    logic         stall;
    logic         taken;
    logic         leave;

    assign op     = opcode_t'(cur.instr[31:26]);
    assign fn     = funct_t'(cur.instr[5:0]);
    assign rsAddr = cur.instr[25:21];
    assign rtAddr = cur.instr[20:16];
    assign immExt = (op == OpLui) ? {cur.instr[15:0], 16'h0} : {{16{cur.instr[15]}}, cur.instr[15:0]};
    assign operandB = (op == OpRType) ? rtData : immExt;

    always_comb begin
        aluOp  = AluAdd;
        kind   = LsAlu;
        dest   = rtAddr;
        writes = 1'b0;
        useRs  = 1'b1;
        useRt  = 1'b0;
        case (op)
            OpRType: begin
                dest   = cur.instr[15:11];
                useRt  = 1'b1;
                writes = 1'b1;
                case (fn)
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnSlt:   aluOp = AluSlt;
                    default: writes = 1'b0; // Unknown function acts as a no-op.
                endcase
            end
            OpAddiu: writes = 1'b1;
            OpLui: begin
                aluOp  = AluLui;
                useRs  = 1'b0;
                writes = 1'b1;
            end
            OpLw: begin
                kind   = LsLoad;
                writes = 1'b1;
            end
            OpSw: begin
                kind  = LsStore;
                useRt = 1'b1;
            end
            OpBeq, OpBne: useRt = 1'b1;
            default: useRs = 1'b0;
        endcase
    end

    always_comb begin
        case (aluOp)
            AluAdd:  aluResult = rsData + operandB;
            AluSub:  aluResult = rsData - operandB;
            AluAnd:  aluResult = rsData & operandB;
            AluOr:   aluResult = rsData | operandB;
            AluXor:  aluResult = rsData ^ operandB;
            AluSlt:  aluResult = {31'd0, $signed(rsData) < $signed(operandB)};
            default: aluResult = operandB; // LUI, immediate already shifted up.
        endcase
    end

    // Wait while the load/store stage still owes a write to one of our sources.
    assign stall = curValid && busyValid && busyDest != 5'd0 &&
                   ((useRs && rsAddr == busyDest) || (useRt && rtAddr == busyDest));
    assign taken = (op == OpBeq && rsData == rtData) || (op == OpBne && rsData != rtData);

    assign lsValid    = curValid && !stall;
    assign leave      = lsValid && lsReady;
    assign redirect   = leave && taken;
    assign redirectPc = cur.pc + 32'd4 + {immExt[29:0], 2'b00};
    assign fetchReady = !curValid || (leave && !taken);
    assign ls = '{kind: kind, dest: dest, wrEn: writes, result: aluResult, storeData: rtData};

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            curValid <= 1'b0;
        else if (fetchValid && fetchReady)
            curValid <= 1'b1;
        else if (leave)
            curValid <= 1'b0;
    end

    always_ff @(posedge Clock) begin
        if (fetchValid && fetchReady)
            cur <= fetch;
    end

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/100ps

module loadStoreUnit (
    input  logic              Clock,
    input  logic              nReset,
    input  cpuPkg::lsBundle_t ls,
    input  logic              lsValid,
    output logic              lsReady,
    output cpuPkg::memReq_t   dataReq,
    input  logic              dataReqReady,
    input  cpuPkg::memRsp_t   dataRsp,
    output logic              wrEn,
    output logic [4:0]        wrAddr,
    output logic [31:0]       wrData,
    output logic [4:0]        busyDest,
    output logic              busyValid
);
    import cpuPkg::*;

    typedef enum logic [1:0] {LsIdle, LsRequest, LsWait} lsState_t;

    lsState_t  state;
    lsBundle_t cur;
    logic      retire;

    // ALU results leave on their first cycle here, memory ops once the response is in.
    assign retire = (state == LsRequest && cur.kind == LsAlu) ||
                    (state == LsWait && dataRsp.valid);
    assign lsReady = (state == LsIdle) || retire;

    always_comb begin
        dataReq.valid = (state == LsRequest) && (cur.kind != LsAlu);
        dataReq.write = (cur.kind == LsStore);
        dataReq.addr  = {cur.result[31:2], 2'b00};
        dataReq.data  = cur.storeData;
    end

    assign wrEn   = retire && cur.wrEn;
    assign wrAddr = cur.dest;
    assign wrData = (cur.kind == LsLoad) ? dataRsp.data : cur.result;

    assign busyDest  = cur.dest;
    assign busyValid = (state != LsIdle) && cur.wrEn && !retire;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            state <= LsIdle;
        else if (lsValid && lsReady)
            state <= LsRequest;
        else if (retire)
            state <= LsIdle;
        else if (dataReq.valid && dataReqReady)
            state <= LsWait;
    end

    always_ff @(posedge Clock) begin
        if (lsValid && lsReady)
            cur <= ls;
    end

endmodule

// ==== src/memArbiter.sv ====
`timescale 1ns/100ps

module memArbiter (
    input  logic            Clock,
    input  logic            nReset,
    input  cpuPkg::memReq_t fetchReq,
    output logic            fetchReqReady,
    output cpuPkg::memRsp_t fetchRsp,
    input  cpuPkg::memReq_t dataReq,
    output logic            dataReqReady,
    output cpuPkg::memRsp_t dataRsp,
    output cpuPkg::memReq_t memReq,
    input  logic            memReqReady,
    input  cpuPkg::memRsp_t memRsp
);
    import cpuPkg::*;

    typedef enum logic [1:0] {ArbIdle, ArbFetch, ArbData} arbState_t;

    arbState_t state;
    logic      accepted;
    logic      grantFetch;
    logic      grantData;

    // The owner is locked from the first cycle its request is shown to memory,
    // so a later data request cannot change a waiting fetch.
    always_comb begin
        grantData  = 1'b0;
        grantFetch = 1'b0;
        case (state)
            ArbIdle: begin
                grantData  = dataReq.valid;
                grantFetch = !dataReq.valid && fetchReq.valid;
            end
            ArbData:  grantData  = !accepted;
            default:  grantFetch = !accepted;
        endcase
    end

    assign memReq        = grantData ? dataReq : (grantFetch ? fetchReq : '0);
    assign dataReqReady  = grantData && memReqReady;
    assign fetchReqReady = grantFetch && memReqReady;

    assign fetchRsp = '{valid: (state == ArbFetch) && accepted && memRsp.valid, data: memRsp.data};
    assign dataRsp  = '{valid: (state == ArbData) && accepted && memRsp.valid, data: memRsp.data};

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            state    <= ArbIdle;
            accepted <= 1'b0;
        end else if (state == ArbIdle) begin
            if (grantData)
                state <= ArbData;
            else if (grantFetch)
                state <= ArbFetch;
            accepted <= memReq.valid && memReqReady;
        end else if (accepted && memRsp.valid) begin
            state    <= ArbIdle;
            accepted <= 1'b0;
        end else if (memReq.valid && memReqReady) begin
            accepted <= 1'b1;
        end
    end

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore #(
    parameter logic [31:0] ResetPc = 32'h0
) (
    input  logic            Clock,
    input  logic            nReset,
    output cpuPkg::memReq_t memReq,
    input  logic            memReqReady,
    input  cpuPkg::memRsp_t memRsp
);
    import cpuPkg::*;

    memReq_t      fetchReq;
    memReq_t      dataReq;
    memRsp_t      fetchRsp;
    memRsp_t      dataRsp;
    logic         fetchReqReady;
    logic         dataReqReady;
    fetchBundle_t fetch;
    logic         fetchValid;
    logic         fetchReady;
    logic         redirect;
    logic [31:0]  redirectPc;
    logic [4:0]   rsAddr;
    logic [4:0]   rtAddr;
    logic [31:0]  rsData;
    logic [31:0]  rtData;
    lsBundle_t    ls;
    logic         lsValid;
    logic         lsReady;
    logic         wrEn;
    logic [4:0]   wrAddr;
    logic [31:0]  wrData;
    logic [4:0]   busyDest;
    logic         busyValid;

    fetchUnit #(.ResetPc(ResetPc)) fetch0 (.*);

    executeStage exec0 (.*);

    regFile regs0 (.*);

    loadStoreUnit lsu0 (.*);

    memArbiter arb0 (.*);

endmodule

// ==== verif/cpuCore_chk.sv ====
`timescale 1ns/100ps

module cpuCore_chk (
    input logic            Clock,
    input logic            nReset,
    input cpuPkg::memReq_t memReq,
    input logic            memReqReady,
    input cpuPkg::memRsp_t memRsp
);

    logic outstanding;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset)
            outstanding <= 1'b0;
        else if (memReq.valid && memReqReady)
            outstanding <= 1'b1;
        else if (memRsp.valid)
            outstanding <= 1'b0;
    end

    reqStable: assert property (@(posedge Clock) disable iff (!nReset)
        memReq.valid && !memReqReady |=> $stable(memReq))
        else $error("memReq changed while waiting for ready");

    rspExpected: assert property (@(posedge Clock) disable iff (!nReset)
        memRsp.valid |-> outstanding)
        else $error("memRsp valid without an outstanding request");

    addrAligned: assert property (@(posedge Clock) disable iff (!nReset)
        memReq.valid |-> memReq.addr[1:0] == 2'b00)
        else $error("memReq address is not word aligned");

    singleOutstanding: assert property (@(posedge Clock) disable iff (!nReset)
        memReq.valid && memReqReady |-> !outstanding)
        else $error("second request accepted while one is outstanding");

    quietInReset: assert property (@(posedge Clock)
        !nReset |-> !memReq.valid)
        else $error("memReq valid while the core is in reset");

endmodule

bind cpuCore cpuCore_chk chk0 (.*);

// ==== verif/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb;
    import cpuPkg::*;

    localparam int MemWords = 256;
    localparam int Timeout  = 4000;
    localparam int LoopN    = 6;

    logic        Clock;
    logic        nReset;
    memReq_t     memReq;
    logic        memReqReady;
    memRsp_t     memRsp;

    logic [31:0] mem [MemWords];
    logic [31:0] lcgState;
    logic        randomMode;
    logic        doneSeen;
    logic        live;
    logic        pending;
    logic        pendWrite;
    logic [31:0] pendAddr;
    int          delay;
    int          progLen;

    cpuCore dut0 (.*);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[30:15]};
    endfunction

    function automatic logic [31:0] fillValue(int index);
        return ~(index * 32'h9E3779B9) ^ 32'h5A5A0000;
    endfunction

    function automatic logic [31:0] signExt(logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    function automatic logic [31:0] regOp(funct_t fn, int rd, int rs, int rt);
        return {OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] immOp(opcode_t op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // One access at a time; the response follows after a delay of zero or more extra cycles.
    always begin
        @(posedge Clock);
        live = nReset;
        if (!live) begin
            pending = 1'b0;
        end else begin
            if (memRsp.valid)
                pending = 1'b0;
            if (memReq.valid && memReqReady) begin
                pending   = 1'b1;
                pendWrite = memReq.write;
                pendAddr  = memReq.addr;
                delay     = randomMode ? int'(nextRandom() % 4) : 0;
                if (memReq.write) begin
                    mem[memReq.addr[9:2]] = memReq.data;
                    if (memReq.addr == 32'h3FC)
                        doneSeen = 1'b1; // Program end marker.
                end
            end
        end
        #1;
        memRsp.valid = pending && delay == 0;
        memRsp.data  = (pending && !pendWrite) ? mem[pendAddr[9:2]] : 32'h0;
        if (pending && delay > 0)
            delay--;
        memReqReady = live && (!randomMode || nextRandom() % 4 != 0);
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic emit(input logic [31:0] word);
        mem[progLen] = word;
        progLen++;
    endtask

    task automatic closeProgram();
        emit(immOp(OpSw, 0, 0, 'h3FC));
        emit(immOp(OpBeq, 0, 0, -1)); // Spin here until the next reset.
    endtask

    task automatic enterReset();
        @(posedge Clock);
        #1;
        nReset   = 1'b0;
        doneSeen = 1'b0;
        for (int i = 0; i < MemWords; i++)
            mem[i] = fillValue(i);
        progLen = 0;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        cycles = 0;
        repeat (5) @(posedge Clock);
        #1;
        nReset = 1'b1;
        while (!doneSeen && cycles < Timeout) begin
            @(negedge Clock);
            cycles++;
        end
        if (!doneSeen)
            failRun($sformatf("Timeout waiting for the done marker of the %s program.", name));
    endtask

    task automatic checkWord(input logic [31:0] addr, input logic [31:0] expected,
                             input string what);
        assert (mem[addr[9:2]] === expected) else
            failRun($sformatf("** Error at %0t: %s at address %h, expected %h, got %h",
                              $time, what, addr, expected, mem[addr[9:2]]));
    endtask

    task automatic aluTest();
        logic [31:0] r [12];
        enterReset();
        r[1]  = {16'h8765, 16'h0000} + signExt(16'h4321);
        r[2]  = signExt(16'hFFFB);
        r[3]  = 32'h123;
        r[4]  = r[1] + r[3];
        r[5]  = r[3] - r[2];
        r[6]  = r[1] & r[2];
        r[7]  = r[1] | r[3];
        r[8]  = r[1] ^ r[2];
        r[9]  = ($signed(r[2]) < $signed(r[3])) ? 32'd1 : 32'd0;
        r[10] = ($signed(r[3]) < $signed(r[2])) ? 32'd1 : 32'd0;
        r[11] = ($signed(r[1]) < $signed(r[3])) ? 32'd1 : 32'd0;
        emit(immOp(OpLui, 1, 0, 'h8765));
        emit(immOp(OpAddiu, 1, 1, 'h4321));
        emit(immOp(OpAddiu, 2, 0, -5));
        emit(immOp(OpAddiu, 3, 0, 'h123));
        emit(regOp(FnAddu, 4, 1, 3));
        emit(regOp(FnSubu, 5, 3, 2));
        emit(regOp(FnAnd, 6, 1, 2));
        emit(regOp(FnOr, 7, 1, 3));
        emit(regOp(FnXor, 8, 1, 2));
        emit(regOp(FnSlt, 9, 2, 3));
        emit(regOp(FnSlt, 10, 3, 2));
        emit(regOp(FnSlt, 11, 1, 3));
        for (int i = 1; i < 12; i++)
            emit(immOp(OpSw, i, 0, 'h200 + 4 * i));
        closeProgram();
        runProgram("ALU");
        for (int i = 1; i < 12; i++)
            checkWord(32'h200 + 4 * i, r[i], "ALU result");
    endtask

    task automatic chainTest();
        logic [31:0] a, b, c, d, e, acc;
        enterReset();
        a   = 32'd7;
        b   = a + a;
        c   = b - a;
        d   = b + 32'd100;
        e   = d + b;
        acc = 32'd0;
        emit(immOp(OpAddiu, 1, 0, 7));
        emit(regOp(FnAddu, 2, 1, 1));
        emit(regOp(FnSubu, 3, 2, 1));
        emit(immOp(OpSw, 2, 0, 'h300));
        emit(immOp(OpLw, 4, 0, 'h300));
        emit(immOp(OpAddiu, 5, 4, 100)); // Uses the load result at once.
        emit(regOp(FnAddu, 6, 5, 4));
        for (int i = 0; i < 5; i++) begin
            emit(immOp(OpAddiu, 7, 7, 3));
            acc = acc + 32'd3;
        end
        emit(immOp(OpAddiu, 8, 0, 'h2F0));
        emit(immOp(OpSw, 6, 8, 'h24));
        emit(immOp(OpSw, 3, 0, 'h304));
        emit(immOp(OpSw, 5, 0, 'h308));
        emit(immOp(OpSw, 7, 0, 'h30C));
        closeProgram();
        runProgram("chain");
        checkWord(32'h304, c, "SUBU after ADDU");
        checkWord(32'h308, d, "ADDIU after LW");
        checkWord(32'h30C, acc, "ADDIU chain");
        checkWord(32'h314, e, "store with a fresh base");
    endtask

    task automatic memTest();
        logic [31:0] x, y, z;
        enterReset();
        x = 32'd11;
        y = signExt(16'hFFEA);
        z = {16'h1234, 16'h0000};
        emit(immOp(OpAddiu, 1, 0, 11));
        emit(immOp(OpAddiu, 2, 0, -22));
        emit(immOp(OpLui, 3, 0, 'h1234));
        emit(immOp(OpSw, 1, 0, 'h240));
        emit(immOp(OpSw, 2, 0, 'h244));
        emit(immOp(OpSw, 3, 0, 'h248));
        emit(immOp(OpLw, 4, 0, 'h248));
        emit(immOp(OpLw, 5, 0, 'h244));
        emit(immOp(OpLw, 6, 0, 'h240));
        emit(regOp(FnAddu, 7, 4, 5));
        emit(regOp(FnAddu, 8, 7, 6));
        emit(immOp(OpSw, 7, 0, 'h24C));
        emit(immOp(OpSw, 8, 0, 'h250));
        emit(immOp(OpSw, 6, 0, 'h254));
        closeProgram();
        runProgram("load/store");
        checkWord(32'h240, x, "stored word");
        checkWord(32'h244, y, "stored word");
        checkWord(32'h248, z, "stored word");
        checkWord(32'h24C, z + y, "sum of loads");
        checkWord(32'h250, z + y + x, "sum of loads");
        checkWord(32'h254, x, "loaded copy");
    endtask

    task automatic branchTest();
        logic [31:0] count, sum;
        enterReset();
        count = 32'd0;
        sum   = 32'd0;
        do begin
            count = count + 32'd1;
            sum   = sum + count;
        end while (count != LoopN);
        emit(immOp(OpAddiu, 3, 0, LoopN));
        emit(immOp(OpAddiu, 1, 1, 1));   // Loop top at word 1.
        emit(regOp(FnAddu, 2, 2, 1));
        emit(immOp(OpBne, 3, 1, -3));
        emit(immOp(OpBeq, 3, 1, 1));     // Taken, jumps over the marker store.
        emit(immOp(OpSw, 3, 0, 'h280));
        emit(immOp(OpBeq, 2, 1, 1));     // Not taken.
        emit(immOp(OpSw, 2, 0, 'h284));
        emit(immOp(OpSw, 1, 0, 'h288));
        closeProgram();
        runProgram("branch");
        checkWord(32'h280, fillValue(32'h280 >> 2), "skipped marker");
        checkWord(32'h284, sum, "loop sum");
        checkWord(32'h288, count, "loop count");
    endtask

    initial begin
        nReset      = 1'b0;
        memReqReady = 1'b0;
        memRsp      = '0;
        lcgState    = 32'd44842;
        randomMode  = 1'b0;
        doneSeen    = 1'b0;
        pending     = 1'b0;
        pendWrite   = 1'b0;
        pendAddr    = 32'h0;
        delay       = 0;
        progLen     = 0;
        aluTest();
        chainTest();
        memTest();
        branchTest();
        randomMode = 1'b1;
        aluTest();
        branchTest();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== flist.f ====
src/cpuPkg.sv
src/regFile.sv
src/fetchUnit.sv
src/executeStage.sv
src/loadStoreUnit.sv
src/memArbiter.sv
src/cpuCore.sv
verif/cpuCore_chk.sv
verif/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
